//--- files.f
+incdir+verilog
verilog/rr_pkg.sv
verilog/physical_register_file.sv
verilog/operand_bypass.sv
verilog/issue_lane_reg.sv
verilog/register_read.sv
sim/rr_sva.sv
sim/rr_checker.sv
sim/tb_register_read.sv

//--- Makefile
SHELL      := /bin/bash

VERILATOR  ?= verilator
TOP        ?= tb_register_read
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_register_read.sv
`include "rr_cfg.svh"

module tb_register_read;

    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_LIMIT    = 50;

    logic               clk;
    logic               rst;
    logic               int0_valid;
    logic               int1_valid;
    logic               mem_valid;
    rr_pkg::iq_uop_t    int0_uop;
    rr_pkg::iq_uop_t    int1_uop;
    rr_pkg::iq_uop_t    mem_uop;
    rr_pkg::wb_bus_t    wb;
    rr_pkg::pipe_ctrl_t pipe_ctrl;
    logic               int0_out_valid;
    logic               int1_out_valid;
    logic               mem_out_valid;
    rr_pkg::rr_pack_t   int0_out;
    rr_pkg::rr_pack_t   int1_out;
    rr_pkg::rr_pack_t   mem_out;
    int                 check_count;
    int                 error_count;
    int                 timeout_count;
    integer             seed;

    always #2 clk = ~clk;

    register_read i_register_read (.*);

    rr_checker i_checker (.*);

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic idle_inputs();
        int0_valid = 1'b0;
        int1_valid = 1'b0;
        mem_valid  = 1'b0;
        int0_uop   = '0;
        int1_uop   = '0;
        mem_uop    = '0;
        wb         = '0;
        pipe_ctrl  = '0;
    endtask

    // Sources limited to p0..p7 so bypass hits are common
    task automatic random_uop(output rr_pkg::iq_uop_t u);
        logic [31:0] r;
        r           = $random(seed);
        u.pc        = $random(seed);
        u.immediate = $random(seed);
        u.ctrl      = r[7:0];
        u.rd_addr   = {3'b000, r[10:8]};
        u.rs1_addr  = {3'b000, r[13:11]};
        u.rs2_addr  = {3'b000, r[16:14]};
        u.rob_tag   = r[20:17];
    endtask

    task automatic random_wb_bus(output rr_pkg::wb_bus_t bus);
        rr_pkg::wb_port_t ports [4];
        logic [31:0]      r;
        for (int i = 0; i < 4; i++) begin
            r                = $random(seed);
            ports[i].valid   = r[0];
            ports[i].wb_addr = {3'b000, r[3:1]};
            ports[i].wb_data = $random(seed);
        end
        bus.alu0   = ports[0];
        bus.alu1   = ports[1];
        bus.muldiv = ports[2];
        bus.load   = ports[3];
    endtask

    task automatic drive_random_cycle();
        logic [31:0] r;
        logic [31:0] k;
        @(negedge clk);
        r = $random(seed);
        k = $random(seed);
        int0_valid = r[0] | r[1];
        int1_valid = r[2] | r[3];
        mem_valid  = r[4] | r[5];
        random_uop(int0_uop);
        random_uop(int1_uop);
        random_uop(mem_uop);
        random_wb_bus(wb);
        pipe_ctrl.recovery_stall   = (r[8:6] == 3'd0);
        pipe_ctrl.kill_mask        = k[15:0];
        pipe_ctrl.load_wakeup_fail = (r[12:9] == 4'd0);
        pipe_ctrl.int_iq_stall     = (r[15:13] == 3'd0);
        pipe_ctrl.rr_mem_stall     = (r[17:16] == 2'd0);
    endtask

    // ----------------------------------------
    // Waits with timeout
    // ----------------------------------------
    task automatic wait_int0_valid();
        int n;
        n = 0;
        while ((int0_out_valid !== 1'b1) && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
        end
        if (int0_out_valid !== 1'b1) begin
            $display("Timeout: int0 lane output never became valid");
            timeout_count++;
        end
    endtask

    task automatic wait_lanes_empty();
        int n;
        n = 0;
        while ((int0_out_valid || int1_out_valid || mem_out_valid) && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
        end
        if (int0_out_valid || int1_out_valid || mem_out_valid) begin
            $display("Timeout: lane outputs still valid after inputs went idle");
            timeout_count++;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed          = 96;
        timeout_count = 0;
        clk           = 1'b0;
        rst           = 1'b1;
        idle_inputs();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Lanes must stay empty while nothing is issued
        repeat (4) @(negedge clk);

        // First micro-op on int0
        int0_valid = 1'b1;
        random_uop(int0_uop);
        @(negedge clk);
        int0_valid = 1'b0;
        wait_int0_valid();

        repeat (RANDOM_CYCLES) drive_random_cycle();

        @(negedge clk);
        idle_inputs();
        wait_lanes_empty();
        repeat (2) @(negedge clk);

        $display("Checks %0d, mismatches %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim/rr_checker.sv
`include "rr_cfg.svh"

module rr_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               int0_valid,
    input  logic               int1_valid,
    input  logic               mem_valid,
    input  rr_pkg::iq_uop_t    int0_uop,
    input  rr_pkg::iq_uop_t    int1_uop,
    input  rr_pkg::iq_uop_t    mem_uop,
    input  rr_pkg::wb_bus_t    wb,
    input  rr_pkg::pipe_ctrl_t pipe_ctrl,
    input  logic               int0_out_valid,
    input  logic               int1_out_valid,
    input  logic               mem_out_valid,
    input  rr_pkg::rr_pack_t   int0_out,
    input  rr_pkg::rr_pack_t   int1_out,
    input  rr_pkg::rr_pack_t   mem_out,
    output int                 check_count,
    output int                 error_count
);

    logic [`RR_XLEN-1:0] shadow    [`RR_PREG_COUNT];
    logic                exp_valid [3];
    rr_pkg::rr_pack_t    exp_pack  [3];
    logic                active;

    // Write-back port by priority rank with ALU0 first
    function automatic rr_pkg::wb_port_t port_at(rr_pkg::wb_bus_t bus, int idx);
        case (idx)
            0:       return bus.alu0;
            1:       return bus.alu1;
            2:       return bus.muldiv;
            default: return bus.load;
        endcase
    endfunction

    // Expected operand for one source address
    function automatic logic [`RR_XLEN-1:0] expected_operand(
        logic [`RR_PREG_AW-1:0] addr,
        rr_pkg::wb_bus_t        bus
    );
        rr_pkg::wb_port_t p;
        if (addr == '0) begin
            return '0;
        end
        for (int i = 0; i < 4; i++) begin
            p = port_at(bus, i);
            if (p.valid && (p.wb_addr == addr)) begin
                return p.wb_data;
            end
        end
        return shadow[addr];
    endfunction

    function automatic string lane_name(int l);
        return (l == 0) ? "int0" : (l == 1) ? "int1" : "mem";
    endfunction

    // ----------------------------------------
    // Shadow register file
    // ----------------------------------------
    always @(posedge clk) begin : shadow_update
        logic [`RR_PREG_COUNT-1:0] taken;
        rr_pkg::wb_port_t          p;
        taken = '0;
        if (rst) begin
            for (int a = 0; a < `RR_PREG_COUNT; a++) begin
                shadow[a] <= '0;
            end
        end else begin
            // First port to claim an address keeps it
            for (int i = 0; i < 4; i++) begin
                p = port_at(wb, i);
                if (p.valid && (p.wb_addr != '0) && !taken[p.wb_addr]) begin
                    shadow[p.wb_addr] <= p.wb_data;
                    taken[p.wb_addr] = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Expected lane registers
    // ----------------------------------------
    always @(posedge clk) begin : lane_model
        rr_pkg::iq_uop_t  uop;
        rr_pkg::rr_pack_t nxt;
        logic             in_v;
        logic             mem;
        active <= !rst;
        for (int l = 0; l < 3; l++) begin
            mem  = (l == 2);
            uop  = (l == 0) ? int0_uop : (l == 1) ? int1_uop : mem_uop;
            in_v = (l == 0) ? int0_valid : (l == 1) ? int1_valid : mem_valid;
            nxt.uop      = uop;
            nxt.rs1_data = expected_operand(uop.rs1_addr, wb);
            nxt.rs2_data = expected_operand(uop.rs2_addr, wb);
            if (rst) begin
                exp_valid[l] <= 1'b0;
                exp_pack[l]  <= '0;
            end else begin
                if (!pipe_ctrl.recovery_stall && !(mem && pipe_ctrl.rr_mem_stall)) begin
                    exp_pack[l] <= nxt;
                end
                if (pipe_ctrl.recovery_stall) begin
                    if (pipe_ctrl.kill_mask[exp_pack[l].uop.rob_tag]) begin
                        exp_valid[l] <= 1'b0;
                    end
                end else if (pipe_ctrl.load_wakeup_fail
                             || (!mem && pipe_ctrl.int_iq_stall)) begin
                    exp_valid[l] <= 1'b0;
                end else begin
                    exp_valid[l] <= in_v;
                end
            end
        end
    end

    // ----------------------------------------
    // Compare on the falling edge
    // ----------------------------------------
    always @(negedge clk) begin : compare
        logic             dut_v;
        rr_pkg::rr_pack_t dut_p;
        if (active !== 1'b1) begin
            check_count = 0;
            error_count = 0;
        end else begin
            for (int l = 0; l < 3; l++) begin
                dut_v = (l == 0) ? int0_out_valid : (l == 1) ? int1_out_valid : mem_out_valid;
                dut_p = (l == 0) ? int0_out : (l == 1) ? int1_out : mem_out;
                check_count++;
                if (dut_v !== exp_valid[l]) begin
                    error_count++;
                    $display("FAIL %0t: %s valid expected %0b got %0b",
                             $time, lane_name(l), exp_valid[l], dut_v);
                end else if (exp_valid[l] && (dut_p !== exp_pack[l])) begin
                    error_count++;
                    $display("FAIL %0t: %s payload expected %h got %h",
                             $time, lane_name(l), exp_pack[l], dut_p);
                end
            end
        end
    end

endmodule

//--- sim/rr_sva.sv
module rr_sva (
    input logic               clk,
    input logic               rst,
    input logic               out_valid,
    input rr_pkg::rr_pack_t   out_pack,
    input rr_pkg::pipe_ctrl_t pipe_ctrl
);

    // ----------------------------------------
    // Reset
    // ----------------------------------------
    property p_reset_clears;
        @(posedge clk) rst |=> (!out_valid && (out_pack == '0));
    endproperty

    a_reset_clears : assert property (p_reset_clears)
        else $error("Lane register not cleared by reset");

    // ----------------------------------------
    // Recovery stall
    // ----------------------------------------

    // Payload frozen for the whole stall
    property p_hold_on_recovery;
        @(posedge clk) disable iff (rst)
            pipe_ctrl.recovery_stall |=> $stable(out_pack);
    endproperty

    a_hold_on_recovery : assert property (p_hold_on_recovery)
        else $error("Lane payload changed under recovery stall");

    // Kill mask hit on the held tag squashes the entry
    property p_kill_clears;
        @(posedge clk) disable iff (rst)
            (pipe_ctrl.recovery_stall && pipe_ctrl.kill_mask[out_pack.uop.rob_tag])
            |=> !out_valid;
    endproperty

    a_kill_clears : assert property (p_kill_clears)
        else $error("Lane valid still set after kill mask hit");

endmodule

bind issue_lane_reg rr_sva i_sva (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_pack  (out_pack),
    .pipe_ctrl (pipe_ctrl)
);

//--- verilog/register_read.sv
`include "rr_cfg.svh"

module register_read (
    input  logic               clk,
    input  logic               rst,
    input  logic               int0_valid,
    input  logic               int1_valid,
    input  logic               mem_valid,
    input  rr_pkg::iq_uop_t    int0_uop,
    input  rr_pkg::iq_uop_t    int1_uop,
    input  rr_pkg::iq_uop_t    mem_uop,
    input  rr_pkg::wb_bus_t    wb,
    input  rr_pkg::pipe_ctrl_t pipe_ctrl,
    output logic               int0_out_valid,
    output logic               int1_out_valid,
    output logic               mem_out_valid,
    output rr_pkg::rr_pack_t   int0_out,
    output rr_pkg::rr_pack_t   int1_out,
    output rr_pkg::rr_pack_t   mem_out
);

    // Lane indices follow int0, int1 and mem
    rr_pkg::iq_uop_t       lane_uop       [3];
    logic                  lane_valid     [3];
    logic                  lane_out_valid [3];
    rr_pkg::rr_pack_t      lane_out       [3];

    logic [`RR_PREG_AW-1:0] prf_rd_addr [6];
    logic [`RR_XLEN-1:0]    prf_rd_data [6];

    assign lane_uop[0]   = int0_uop;
    assign lane_uop[1]   = int1_uop;
    assign lane_uop[2]   = mem_uop;
    assign lane_valid[0] = int0_valid;
    assign lane_valid[1] = int1_valid;
    assign lane_valid[2] = mem_valid;

    physical_register_file i_prf (
        .clk     (clk),
        .rst     (rst),
        .rd_addr (prf_rd_addr),
        .rd_data (prf_rd_data),
        .wb      (wb)
    );

    // ----------------------------------------
    // Per lane operand resolve and register
    // ----------------------------------------
    for (genvar l = 0; l < 3; l++) begin : g_lane
        rr_pkg::rr_pack_t    in_pack;
        logic [`RR_XLEN-1:0] rs1_op;
        logic [`RR_XLEN-1:0] rs2_op;

        // Read ports 2l and 2l+1 belong to this lane
        assign prf_rd_addr[2*l]   = lane_uop[l].rs1_addr;
        assign prf_rd_addr[2*l+1] = lane_uop[l].rs2_addr;

        operand_bypass i_bypass_rs1 (
            .rs_addr  (lane_uop[l].rs1_addr),
            .prf_data (prf_rd_data[2*l]),
            .wb       (wb),
            .operand  (rs1_op)
        );

        operand_bypass i_bypass_rs2 (
            .rs_addr  (lane_uop[l].rs2_addr),
            .prf_data (prf_rd_data[2*l+1]),
            .wb       (wb),
            .operand  (rs2_op)
        );

        assign in_pack.uop      = lane_uop[l];
        assign in_pack.rs1_data = rs1_op;
        assign in_pack.rs2_data = rs2_op;

        issue_lane_reg #(
            .is_mem_lane (l == 2)
        ) i_lane (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (lane_valid[l]),
            .in_pack   (in_pack),
            .pipe_ctrl (pipe_ctrl),
            .out_valid (lane_out_valid[l]),
            .out_pack  (lane_out[l])
        );
    end

    assign int0_out_valid = lane_out_valid[0];
    assign int1_out_valid = lane_out_valid[1];
    assign mem_out_valid  = lane_out_valid[2];
    assign int0_out       = lane_out[0];
    assign int1_out       = lane_out[1];
    assign mem_out        = lane_out[2];

endmodule

//--- verilog/issue_lane_reg.sv
`include "rr_cfg.svh"

module issue_lane_reg #(
    parameter bit is_mem_lane = 1'b0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  rr_pkg::rr_pack_t   in_pack,
    input  rr_pkg::pipe_ctrl_t pipe_ctrl,
    output logic               out_valid,
    output rr_pkg::rr_pack_t   out_pack
);

    logic                     hold_pack;
    logic                     flush;
    logic                     killed;
    logic [`RR_ROB_TAG_W-1:0] held_tag;

    // ----------------------------------------
    // Stall and kill decode
    // ----------------------------------------

    // Memory lane also waits on the memory pipe
    assign hold_pack = pipe_ctrl.recovery_stall
                     || (is_mem_lane && pipe_ctrl.rr_mem_stall);

    // Integer queue stall only squashes the integer lanes
    assign flush = pipe_ctrl.load_wakeup_fail
                 || (!is_mem_lane && pipe_ctrl.int_iq_stall);

    // Kill lookup uses the tag of the entry currently held
    assign held_tag = out_pack.uop.rob_tag;
    assign killed   = pipe_ctrl.kill_mask[held_tag];

    // ----------------------------------------
    // Payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            out_pack <= '0;
        end else if (!hold_pack) begin
            out_pack <= in_pack;
        end
    end

    // ----------------------------------------
    // Valid
    // ----------------------------------------

    // Valid follows the input even under rr_mem_stall
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (pipe_ctrl.recovery_stall) begin
            if (killed) begin
                out_valid <= 1'b0;
            end
        end else if (flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

//--- verilog/operand_bypass.sv
`include "rr_cfg.svh"

module operand_bypass (
    input  logic [`RR_PREG_AW-1:0] rs_addr,
    input  logic [`RR_XLEN-1:0]    prf_data,
    input  rr_pkg::wb_bus_t        wb,
    output logic [`RR_XLEN-1:0]    operand
);

    logic hit_alu0;
    logic hit_alu1;
    logic hit_muldiv;
    logic hit_load;

    // Match of the source against each write-back port
    assign hit_alu0   = wb.alu0.valid   && (wb.alu0.wb_addr   == rs_addr);
    assign hit_alu1   = wb.alu1.valid   && (wb.alu1.wb_addr   == rs_addr);
    assign hit_muldiv = wb.muldiv.valid && (wb.muldiv.wb_addr == rs_addr);
    assign hit_load   = wb.load.valid   && (wb.load.wb_addr   == rs_addr);

    // Zero register first, then write-back in fixed order, then the file
    always_comb begin
        if (rs_addr == '0) begin
            operand = '0;
        end else if (hit_alu0) begin
            operand = wb.alu0.wb_data;
        end else if (hit_alu1) begin
            operand = wb.alu1.wb_data;
        end else if (hit_muldiv) begin
            operand = wb.muldiv.wb_data;
        end else if (hit_load) begin
            operand = wb.load.wb_data;
        end else begin
            operand = prf_data;
        end
    end

endmodule

//--- verilog/physical_register_file.sv
`include "rr_cfg.svh"

module physical_register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RR_PREG_AW-1:0] rd_addr [6],
    output logic [`RR_XLEN-1:0]    rd_data [6],
    input  rr_pkg::wb_bus_t        wb
);

    localparam int NUM_RD = 6;
    localparam int NUM_WR = 4;

    logic [`RR_XLEN-1:0] regs [`RR_PREG_COUNT];
    rr_pkg::wb_port_t    wr_port [NUM_WR];

    // ----------------------------------------
    // Write ports
    // ----------------------------------------

    // Index 0 has the highest priority
    assign wr_port[0] = wb.alu0;
    assign wr_port[1] = wb.alu1;
    assign wr_port[2] = wb.muldiv;
    assign wr_port[3] = wb.load;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RR_PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Lowest priority first so that a later hit on the same address overrides it
            for (int p = NUM_WR - 1; p >= 0; p--) begin
                if (wr_port[p].valid && (wr_port[p].wb_addr != '0)) begin
                    regs[wr_port[p].wb_addr] <= wr_port[p].wb_data;
                end
            end
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------

    // Two combinational read ports per lane
    always_comb begin
        for (int r = 0; r < NUM_RD; r++) begin
            rd_data[r] = regs[rd_addr[r]];
        end
    end

endmodule

//--- verilog/rr_pkg.sv
`include "rr_cfg.svh"

package rr_pkg;

    // ----------------------------------------
    // Scalar fields
    // ----------------------------------------
    typedef logic [`RR_XLEN-1:0]      xlen_t;
    typedef logic [`RR_PREG_AW-1:0]   preg_addr_t;
    typedef logic [`RR_ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [`RR_CTRL_W-1:0]    uop_ctrl_t;

    // ----------------------------------------
    // Write-back
    // ----------------------------------------

    // One execution unit result toward the register file
    typedef struct packed {
        logic       valid;
        preg_addr_t wb_addr;
        xlen_t      wb_data;
    } wb_port_t;

    // All four write-back sources in bypass priority order
    typedef struct packed {
        wb_port_t alu0;
        wb_port_t alu1;
        wb_port_t muldiv;
        wb_port_t load;
    } wb_bus_t;

    // ----------------------------------------
    // Micro-op payloads
    // ----------------------------------------

    // Issued micro-op as it leaves the issue queue
    typedef struct packed {
        xlen_t      pc;
        xlen_t      immediate;
        // Opaque to this stage and decoded by the execution units
        uop_ctrl_t  ctrl;
        preg_addr_t rd_addr;
        preg_addr_t rs1_addr;
        preg_addr_t rs2_addr;
        rob_tag_t   rob_tag;
    } iq_uop_t;

    // Micro-op with both source operands resolved
    typedef struct packed {
        iq_uop_t uop;
        xlen_t   rs1_data;
        xlen_t   rs2_data;
    } rr_pack_t;

    // ----------------------------------------
    // Pipeline control
    // ----------------------------------------
    typedef struct packed {
        logic                     recovery_stall;
        // Set bit means the ROB entry with that tag is squashed
        logic [`RR_ROB_DEPTH-1:0] kill_mask;
        logic                     load_wakeup_fail;
        logic                     int_iq_stall;
        logic                     rr_mem_stall;
    } pipe_ctrl_t;

endpackage

//--- verilog/rr_cfg.svh
`ifndef RR_CFG_SVH
`define RR_CFG_SVH

// ----------------------------------------
// Datapath
// ----------------------------------------

// Integer data width
`define RR_XLEN 32

// ----------------------------------------
// Physical register file
// ----------------------------------------
`define RR_PREG_COUNT 64
`define RR_PREG_AW 6

// ----------------------------------------
// Reorder buffer and micro-op control
// ----------------------------------------

// One kill mask bit per ROB entry
`define RR_ROB_DEPTH 16
`define RR_ROB_TAG_W 4
`define RR_CTRL_W 8

`endif
